/* verilog/pip_types.sv */
package pip_types;

  // ALU opcodes as {opcode, funct} of the instruction word
  typedef enum logic [11:0] {
    OP_SLL    = 12'h000,
    OP_SRL    = 12'h002,
    OP_SRA    = 12'h003,
    OP_MOVZ   = 12'h00a,
    OP_MOVN   = 12'h00b,
    OP_ADD    = 12'h020,
    OP_SUB    = 12'h022,
    OP_AND    = 12'h024,
    OP_OR     = 12'h025,
    OP_XOR    = 12'h026,
    OP_NOR    = 12'h027,
    OP_LUI    = 12'h3c0,
    OP_MUL_LO = 12'h702,
    // SPECIAL3 group
    OP_EXT    = 12'h7c0,
    OP_INS    = 12'h7c4,
    OP_SEB    = 12'h7e0,
    OP_SEH    = 12'h7e1,
    // No instruction encoding, used by decode for moves
    OP_PASS_A = 12'hfe0,
    OP_PASS_B = 12'hfe1
  } alu_op_t;

  // HI/LO unit operations
  typedef enum logic [2:0] {
    OP_NONE = 3'd0,
    OP_MUL  = 3'd1,
    OP_MADD = 3'd2,
    OP_DIV  = 3'd3,
    OP_MTHI = 3'd4,
    OP_MTLO = 3'd5,
    OP_MFHI = 3'd6,
    OP_MFLO = 3'd7
  } muldiv_op_t;

  // Final result source
  typedef enum logic [1:0] {
    RES_ALU  = 2'd0,
    RES_SET  = 2'd1,
    RES_LINK = 2'd2
  } alu_res_t;

  // Branch conditions
  typedef enum logic [2:0] {
    COND_EQ  = 3'd0,
    COND_NE  = 3'd1,
    COND_GEZ = 3'd2,
    COND_GTZ = 3'd3,
    COND_LEZ = 3'd4,
    COND_LTZ = 3'd5
  } cond_t;

endpackage

/* verilog/muldiv_if.sv */
`timescale 1ns/1ps

interface muldiv_if (
  input pip_types::muldiv_op_t op,
  input logic                  op_u
);

  logic [31:0] hi;
  logic [31:0] lo;
  logic [31:0] mul_lo;
  logic        busy;

  modport unit (input op, input op_u, output hi, output lo, output mul_lo, output busy);

  modport user (input op, input op_u, input hi, input lo, input mul_lo);

endinterface

/* verilog/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward (
  input  logic        clock,
  input  logic        reset_n,
  input  logic [31:0] a_val,
  input  logic [31:0] b_val,
  input  logic [31:0] result_from_ex_mem,
  input  logic [31:0] result_from_mem_wb,
  input  logic [4:0]  ex_mem_dest_reg,
  input  logic        ex_mem_dest_reg_valid,
  input  logic [4:0]  mem_wb_dest_reg,
  input  logic        mem_wb_dest_reg_valid,
  input  logic [4:0]  a_reg,
  input  logic        a_reg_valid,
  input  logic [4:0]  b_reg,
  input  logic        b_reg_valid,
  input  logic [31:0] imm,
  input  logic        imm_valid,
  input  logic        stall,
  output logic [31:0] op_a,
  output logic [31:0] op_b,
  output logic [31:0] op_b_fwd
);

  // Hit flags ordered {a_ex_mem, a_mem_wb, b_ex_mem, b_mem_wb}
  logic [3:0]  hit;
  logic [3:0]  hit_q;
  logic        stall_d1;
  logic        capture;
  logic [31:0] ex_mem_q;
  logic [31:0] mem_wb_q;

  // EX/MEM wins over MEM/WB
  function automatic logic [31:0] pick(input logic        hit_em,
                                       input logic        hit_mw,
                                       input logic [31:0] reg_val,
                                       input logic [31:0] em_val,
                                       input logic [31:0] mw_val);
    pick = hit_em ? em_val : (hit_mw ? mw_val : reg_val);
  endfunction

  assign hit[3] = a_reg_valid && ex_mem_dest_reg_valid && (a_reg == ex_mem_dest_reg);
  assign hit[2] = a_reg_valid && mem_wb_dest_reg_valid && (a_reg == mem_wb_dest_reg);
  assign hit[1] = b_reg_valid && ex_mem_dest_reg_valid && (b_reg == ex_mem_dest_reg);
  assign hit[0] = b_reg_valid && mem_wb_dest_reg_valid && (b_reg == mem_wb_dest_reg);

  assign capture = stall && !stall_d1;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      stall_d1 <= 1'b0;
      hit_q    <= '0;
    end else begin
      stall_d1 <= stall;
      if (capture)
        hit_q <= hit;
    end
  end

  // Later stages move on during a stall so keep what they held
  always_ff @(posedge clock) begin
    if (capture) begin
      ex_mem_q <= result_from_ex_mem;
      mem_wb_q <= result_from_mem_wb;
    end
  end

  assign op_a = stall_d1 ? pick(hit_q[3], hit_q[2], a_val, ex_mem_q, mem_wb_q)
                         : pick(hit[3], hit[2], a_val, result_from_ex_mem, result_from_mem_wb);

  assign op_b_fwd = stall_d1 ? pick(hit_q[1], hit_q[0], b_val, ex_mem_q, mem_wb_q)
                             : pick(hit[1], hit[0], b_val, result_from_ex_mem,
                                    result_from_mem_wb);

  assign op_b = imm_valid ? imm : op_b_fwd;

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic [31:0]        op_a,
  input  logic [31:0]        op_b,
  input  logic [31:0]        op_b_fwd,
  input  logic [31:0]        pc,
  input  logic [31:0]        imm,
  input  logic [4:0]         shamt,
  input  logic               a_reg_valid,
  input  pip_types::alu_op_t  alu_op,
  input  pip_types::alu_res_t alu_res_sel,
  input  logic               alu_set_u,
  muldiv_if.user             md,
  output logic [31:0]        result,
  output logic [31:0]        result_2,
  output logic               inval_dest_reg
);

  logic [4:0]  sh;
  logic [4:0]  fld_lsb;
  logic [4:0]  fld_msbd;
  logic [31:0] fld_mask;
  logic [31:0] ins_mask;
  logic [31:0] alu_res;
  logic [32:0] diff;
  logic        slt_u;
  logic        slt_s;
  logic [31:0] set_res;

  // Variable shifts take the amount from rs
  assign sh = a_reg_valid ? op_a[4:0] : shamt;

  // Field width minus one in imm[15:11]
  assign fld_lsb  = imm[10:6];
  assign fld_msbd = imm[15:11];
  assign fld_mask = 32'hffff_ffff >> (5'd31 - fld_msbd);
  assign ins_mask = fld_mask << fld_lsb;

  always_comb begin
    case (alu_op)
      pip_types::OP_ADD:    alu_res = op_a + op_b;
      pip_types::OP_SUB:    alu_res = op_a - op_b;
      pip_types::OP_OR:     alu_res = op_a | op_b;
      pip_types::OP_XOR:    alu_res = op_a ^ op_b;
      pip_types::OP_NOR:    alu_res = ~(op_a | op_b);
      pip_types::OP_AND:    alu_res = op_a & op_b;
      pip_types::OP_PASS_A: alu_res = op_a;
      pip_types::OP_PASS_B: alu_res = op_b;
      pip_types::OP_SLL:    alu_res = op_b << sh;
      pip_types::OP_SRL:    alu_res = op_b >> sh;
      pip_types::OP_SRA:    alu_res = $signed(op_b) >>> sh;
      pip_types::OP_LUI:    alu_res = {op_b[15:0], 16'h0000};
      pip_types::OP_MUL_LO: alu_res = md.mul_lo;
      pip_types::OP_MOVZ:   alu_res = op_a;
      pip_types::OP_MOVN:   alu_res = op_a;
      pip_types::OP_SEB:    alu_res = {{24{op_b[7]}}, op_b[7:0]};
      pip_types::OP_SEH:    alu_res = {{16{op_b[15]}}, op_b[15:0]};
      pip_types::OP_EXT:    alu_res = (op_a >> fld_lsb) & fld_mask;
      // Immediate overrides op_b so rt comes from the forwarded value
      pip_types::OP_INS:    alu_res = ((op_a << fld_lsb) & ins_mask) | (op_b_fwd & ~ins_mask);
      default:              alu_res = '0;
    endcase
  end

  // Borrow gives the unsigned compare and the sign the signed one
  assign diff  = {1'b0, op_a} - {1'b0, op_b};
  assign slt_u = diff[32];
  assign slt_s = (op_a[31] & ~op_b[31]) | (diff[31] & ~(op_a[31] ^ op_b[31]));
  assign set_res = {31'b0, alu_set_u ? slt_u : slt_s};

  always_comb begin
    if (md.op == pip_types::OP_MFHI) begin
      result = md.hi;
    end else if (md.op == pip_types::OP_MFLO) begin
      result = md.lo;
    end else begin
      case (alu_res_sel)
        pip_types::RES_SET:  result = set_res;
        pip_types::RES_LINK: result = pc + 32'd8;
        default:             result = alu_res;
      endcase
    end
  end

  // Store data
  assign result_2 = op_b_fwd;

  assign inval_dest_reg = ((alu_op == pip_types::OP_MOVZ) && (op_b_fwd != 32'd0))
                       || ((alu_op == pip_types::OP_MOVN) && (op_b_fwd == 32'd0));

endmodule

/* verilog/muldiv_unit.sv */
`timescale 1ns/1ps

module muldiv_unit #(
  parameter int MUL_CYCLES = 5,
  parameter int DIV_CYCLES = 35
) (
  input  logic        clock,
  input  logic        reset_n,
  input  logic [31:0] op_a,
  input  logic [31:0] op_b,
  input  logic        front_stall,
  muldiv_if.unit      md,
  output logic        stall
);

  localparam int MAX_CYCLES = (DIV_CYCLES > MUL_CYCLES) ? DIV_CYCLES : MUL_CYCLES;
  localparam int CNT_W      = $clog2(MAX_CYCLES + 1);

  logic             long_op;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_last;
  logic [63:0]      prod;
  logic [31:0]      quo;
  logic [31:0]      rem;
  logic [31:0]      hi_r;
  logic [31:0]      lo_r;
  logic [31:0]      hi_next;
  logic [31:0]      lo_next;
  logic             load_hi;
  logic             load_lo;

  assign long_op = md.op inside {pip_types::OP_MUL, pip_types::OP_MADD, pip_types::OP_DIV};

  assign cnt_last = (md.op == pip_types::OP_DIV) ? CNT_W'(DIV_CYCLES - 1)
                                                 : CNT_W'(MUL_CYCLES - 1);

  // Busy until the count reaches the last cycle of the operation
  assign md.busy = long_op && (cnt != cnt_last);
  assign stall   = long_op ? md.busy : front_stall;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      cnt <= '0;
    else if (md.busy)
      cnt <= cnt + 1'b1;
    else
      cnt <= '0;
  end

  always_comb begin
    if (md.op_u) begin
      prod = {32'b0, op_a} * {32'b0, op_b};
      quo  = op_a / op_b;
      rem  = op_a % op_b;
    end else begin
      prod = $signed({{32{op_a[31]}}, op_a}) * $signed({{32{op_b[31]}}, op_b});
      quo  = $signed(op_a) / $signed(op_b);
      rem  = $signed(op_a) % $signed(op_b);
    end
  end

  always_comb begin
    hi_next = op_a;
    lo_next = op_a;
    case (md.op)
      pip_types::OP_MUL:  {hi_next, lo_next} = prod;
      pip_types::OP_MADD: {hi_next, lo_next} = {hi_r, lo_r} + prod;
      pip_types::OP_DIV: begin
        hi_next = rem;
        lo_next = quo;
      end
      default: ;
    endcase
  end

  assign load_hi = long_op || (md.op == pip_types::OP_MTHI);
  assign load_lo = long_op || (md.op == pip_types::OP_MTLO);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      hi_r <= '0;
      lo_r <= '0;
    end else if (!stall) begin
      if (load_hi)
        hi_r <= hi_next;
      if (load_lo)
        lo_r <= lo_next;
    end
  end

  assign md.hi     = hi_r;
  assign md.lo     = lo_r;
  assign md.mul_lo = prod[31:0];

endmodule

/* verilog/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
  input  logic [31:0]      pc,
  input  logic [31:0]      imm,
  input  logic [31:0]      op_a,
  input  logic [31:0]      op_b_fwd,
  input  logic             jmp_inst,
  input  logic             branch_inst,
  input  pip_types::cond_t branch_cond,
  input  logic             stall,
  input  logic             branch_stall,
  output logic [31:0]      new_pc,
  output logic             new_pc_valid
);

  logic a_eqz;
  logic a_neg;
  logic cond_ok;

  assign a_eqz = (op_a == 32'd0);
  assign a_neg = op_a[31];

  // Compare against rt uses the forwarded value since op_b may hold the immediate
  always_comb begin
    case (branch_cond)
      pip_types::COND_EQ:  cond_ok = (op_a == op_b_fwd);
      pip_types::COND_NE:  cond_ok = (op_a != op_b_fwd);
      pip_types::COND_GEZ: cond_ok = !a_neg;
      pip_types::COND_GTZ: cond_ok = !a_neg && !a_eqz;
      pip_types::COND_LEZ: cond_ok = a_neg || a_eqz;
      pip_types::COND_LTZ: cond_ok = a_neg;
      default:             cond_ok = 1'b0;
    endcase
  end

  assign new_pc_valid = (jmp_inst || (branch_inst && cond_ok)) && !stall && !branch_stall;

  // Target already computed by decode
  assign new_pc = new_pc_valid ? imm : pc;

endmodule

/* verilog/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage #(
  parameter int MUL_CYCLES = 5,
  parameter int DIV_CYCLES = 35
) (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic [31:0]           pc,
  input  logic [31:0]           a_val,
  input  logic [31:0]           b_val,
  input  logic [31:0]           result_from_ex_mem,
  input  logic [31:0]           result_from_mem_wb,
  input  logic [4:0]            a_reg,
  input  logic                  a_reg_valid,
  input  logic [4:0]            b_reg,
  input  logic                  b_reg_valid,
  input  logic [4:0]            ex_mem_dest_reg,
  input  logic                  ex_mem_dest_reg_valid,
  input  logic [4:0]            mem_wb_dest_reg,
  input  logic                  mem_wb_dest_reg_valid,
  input  logic [31:0]           imm,
  input  logic                  imm_valid,
  input  logic [4:0]            shamt,
  input  pip_types::alu_op_t     alu_op,
  input  pip_types::alu_res_t    alu_res_sel,
  input  logic                  alu_set_u,
  input  pip_types::muldiv_op_t  muldiv_op,
  input  logic                  muldiv_op_u,
  input  logic                  jmp_inst,
  input  logic                  branch_inst,
  input  pip_types::cond_t       branch_cond,
  input  logic                  front_stall,
  input  logic                  branch_stall,
  output logic [31:0]           result,
  output logic [31:0]           result_2,
  output logic [31:0]           new_pc,
  output logic                  new_pc_valid,
  output logic                  inval_dest_reg,
  output logic                  stall
);

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] op_b_fwd;

  muldiv_if md (
    .op   (muldiv_op),
    .op_u (muldiv_op_u)
  );

  operand_forward u_fwd (
    .clock                 (clock),
    .reset_n               (reset_n),
    .a_val                 (a_val),
    .b_val                 (b_val),
    .result_from_ex_mem    (result_from_ex_mem),
    .result_from_mem_wb    (result_from_mem_wb),
    .ex_mem_dest_reg       (ex_mem_dest_reg),
    .ex_mem_dest_reg_valid (ex_mem_dest_reg_valid),
    .mem_wb_dest_reg       (mem_wb_dest_reg),
    .mem_wb_dest_reg_valid (mem_wb_dest_reg_valid),
    .a_reg                 (a_reg),
    .a_reg_valid           (a_reg_valid),
    .b_reg                 (b_reg),
    .b_reg_valid           (b_reg_valid),
    .imm                   (imm),
    .imm_valid             (imm_valid),
    .stall                 (stall),
    .op_a                  (op_a),
    .op_b                  (op_b),
    .op_b_fwd              (op_b_fwd)
  );

  alu u_alu (
    .op_a           (op_a),
    .op_b           (op_b),
    .op_b_fwd       (op_b_fwd),
    .pc             (pc),
    .imm            (imm),
    .shamt          (shamt),
    .a_reg_valid    (a_reg_valid),
    .alu_op         (alu_op),
    .alu_res_sel    (alu_res_sel),
    .alu_set_u      (alu_set_u),
    .md             (md.user),
    .result         (result),
    .result_2       (result_2),
    .inval_dest_reg (inval_dest_reg)
  );

  muldiv_unit #(
    .MUL_CYCLES (MUL_CYCLES),
    .DIV_CYCLES (DIV_CYCLES)
  ) u_muldiv (
    .clock       (clock),
    .reset_n     (reset_n),
    .op_a        (op_a),
    .op_b        (op_b),
    .front_stall (front_stall),
    .md          (md.unit),
    .stall       (stall)
  );

  branch_unit u_branch (
    .pc           (pc),
    .imm          (imm),
    .op_a         (op_a),
    .op_b_fwd     (op_b_fwd),
    .jmp_inst     (jmp_inst),
    .branch_inst  (branch_inst),
    .branch_cond  (branch_cond),
    .stall        (stall),
    .branch_stall (branch_stall),
    .new_pc       (new_pc),
    .new_pc_valid (new_pc_valid)
  );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD       = 8.0,
  parameter int  RESET_CYCLES = 8
) (
  output logic clock,
  output logic reset_n
);

  initial begin
    clock   = 1'b0;
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
  end

  always #(PERIOD / 2.0) clock = ~clock;

endmodule

/* tb/ex_checker.sv */
`timescale 1ns/1ps

module ex_checker (
  input  logic        clock,
  input  logic        chk_en,
  input  logic        front_stall,
  input  logic        chk_res,
  input  logic [31:0] exp_res,
  input  logic [31:0] exp_r2,
  input  logic [31:0] exp_npc,
  input  logic        exp_npcv,
  input  logic        exp_inval,
  input  int          exp_stall,
  input  logic [31:0] result,
  input  logic [31:0] result_2,
  input  logic [31:0] new_pc,
  input  logic        new_pc_valid,
  input  logic        inval_dest_reg,
  input  logic        stall,
  output int          errors
);

  int stall_cnt;

  task automatic report(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  initial begin
    errors    = 0;
    stall_cnt = 0;
  end

  // Compare on every cycle of a row that is not held by the HI/LO unit
  always @(posedge clock) begin
    if (chk_en) begin
      if (!stall || front_stall) begin
        if (chk_res && result !== exp_res)
          report("result", result, exp_res);
        if (result_2 !== exp_r2)
          report("result_2", result_2, exp_r2);
        if (new_pc !== exp_npc)
          report("new_pc", new_pc, exp_npc);
        if (new_pc_valid !== exp_npcv)
          report("new_pc_valid", 32'(new_pc_valid), 32'(exp_npcv));
        if (inval_dest_reg !== exp_inval)
          report("inval_dest_reg", 32'(inval_dest_reg), 32'(exp_inval));
        if (stall !== front_stall)
          report("stall", 32'(stall), 32'(front_stall));
        if (exp_stall >= 0 && stall_cnt != exp_stall)
          report("stall cycles", 32'(stall_cnt), 32'(exp_stall));
        stall_cnt = 0;
      end else begin
        stall_cnt++;
      end
    end
  end

endmodule

/* tb/ex_tb.sv */
`timescale 1ns/1ps

module ex_tb;

  localparam int MUL_CYCLES = 5;
  localparam int DIV_CYCLES = 35;
  localparam int PERIOD     = 8;

  typedef struct packed {
    pip_types::alu_op_t    op;
    pip_types::alu_res_t   sel;
    logic                  set_u;
    pip_types::muldiv_op_t md_op;
    logic                  md_u;
    logic [4:0]            a_reg;
    logic [4:0]            b_reg;
    logic [4:0]            em_dest;
    logic [4:0]            mw_dest;
    logic                  a_v;
    logic                  b_v;
    logic                  em_v;
    logic                  mw_v;
    logic [31:0]           pc;
    logic [31:0]           a;
    logic [31:0]           b;
    logic [31:0]           em;
    logic [31:0]           mw;
    logic [31:0]           imm;
    logic                  imm_v;
    logic [4:0]            shamt;
    logic                  jmp;
    logic                  br;
    pip_types::cond_t      cond;
    logic                  fs;
    logic                  scramble;
    logic                  chk_res;
    logic [31:0]           exp_res;
    logic [31:0]           exp_r2;
    logic [31:0]           exp_npc;
    logic                  exp_npcv;
    logic                  exp_inval;
    int                    exp_stall;
  } row_t;

  logic        clock;
  logic        reset_n;
  logic        chk_en;
  logic [31:0] result;
  logic [31:0] result_2;
  logic [31:0] new_pc;
  logic        new_pc_valid;
  logic        inval_dest_reg;
  logic        stall;
  int          errors;
  row_t        cur;
  row_t        rows[$];
  logic [31:0] seed;

  tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(8)) u_clk (.clock(clock), .reset_n(reset_n));

  ex_stage #(.MUL_CYCLES(MUL_CYCLES), .DIV_CYCLES(DIV_CYCLES)) DUT (
    .clock(clock), .reset_n(reset_n), .pc(cur.pc), .a_val(cur.a), .b_val(cur.b),
    .result_from_ex_mem(cur.em), .result_from_mem_wb(cur.mw),
    .a_reg(cur.a_reg), .a_reg_valid(cur.a_v), .b_reg(cur.b_reg), .b_reg_valid(cur.b_v),
    .ex_mem_dest_reg(cur.em_dest), .ex_mem_dest_reg_valid(cur.em_v),
    .mem_wb_dest_reg(cur.mw_dest), .mem_wb_dest_reg_valid(cur.mw_v),
    .imm(cur.imm), .imm_valid(cur.imm_v), .shamt(cur.shamt), .alu_op(cur.op),
    .alu_res_sel(cur.sel), .alu_set_u(cur.set_u), .muldiv_op(cur.md_op),
    .muldiv_op_u(cur.md_u), .jmp_inst(cur.jmp), .branch_inst(cur.br),
    .branch_cond(cur.cond), .front_stall(cur.fs), .branch_stall(1'b0),
    .result(result), .result_2(result_2), .new_pc(new_pc), .new_pc_valid(new_pc_valid),
    .inval_dest_reg(inval_dest_reg), .stall(stall)
  );

  ex_checker u_chk (
    .clock(clock), .chk_en(chk_en), .front_stall(cur.fs), .chk_res(cur.chk_res),
    .exp_res(cur.exp_res), .exp_r2(cur.exp_r2), .exp_npc(cur.exp_npc),
    .exp_npcv(cur.exp_npcv), .exp_inval(cur.exp_inval), .exp_stall(cur.exp_stall),
    .result(result), .result_2(result_2), .new_pc(new_pc), .new_pc_valid(new_pc_valid),
    .inval_dest_reg(inval_dest_reg), .stall(stall), .errors(errors)
  );

  function logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic row_t blank_row(input int idx);
    row_t r;
    r           = '0;
    r.op        = pip_types::OP_ADD;
    r.pc        = 32'h0000_1000 + 32'(idx * 4);
    r.exp_npc   = r.pc;
    r.chk_res   = 1'b1;
    return r;
  endfunction

  // Newest matching stage supplies B with EX/MEM first
  function automatic logic [31:0] forwarded_b(input row_t r);
    if (r.b_v && r.em_v && r.b_reg == r.em_dest)
      return r.em;
    if (r.b_v && r.mw_v && r.b_reg == r.mw_dest)
      return r.mw;
    return r.b;
  endfunction

  task automatic push_row(input row_t r);
    r.exp_r2    = forwarded_b(r);
    r.exp_inval = (r.op == pip_types::OP_MOVZ && r.exp_r2 != 0)
               || (r.op == pip_types::OP_MOVN && r.exp_r2 == 0);
    if (r.md_op == pip_types::OP_MUL || r.md_op == pip_types::OP_MADD)
      r.exp_stall = MUL_CYCLES - 1;
    else if (r.md_op == pip_types::OP_DIV)
      r.exp_stall = DIV_CYCLES - 1;
    rows.push_back(r);
  endtask

  task automatic alu_row(input pip_types::alu_op_t op, input pip_types::alu_res_t sel,
                         input logic set_u, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] imm, input logic imm_v, input logic [4:0] shamt,
                         input logic a_v, input logic [31:0] exp);
    row_t r;
    r         = blank_row(rows.size());
    r.op      = op;
    r.sel     = sel;
    r.set_u   = set_u;
    r.a       = a;
    r.b       = b;
    r.imm     = imm;
    r.imm_v   = imm_v;
    r.shamt   = shamt;
    r.a_v     = a_v;
    r.exp_res = (sel == pip_types::RES_LINK) ? r.pc + 32'd8 : exp;
    push_row(r);
  endtask

  task automatic fwd_row(input logic [31:0] a, input logic [31:0] b, input logic [31:0] em,
                         input logic [31:0] mw, input logic [4:0] em_dest, input logic em_v,
                         input logic [4:0] mw_dest, input logic mw_v, input logic imm_v,
                         input logic [31:0] imm, input logic [31:0] exp);
    row_t r;
    r         = blank_row(rows.size());
    r.a_reg   = 5'd3;
    r.b_reg   = 5'd4;
    r.a_v     = 1'b1;
    r.b_v     = 1'b1;
    r.a       = a;
    r.b       = b;
    r.em      = em;
    r.mw      = mw;
    r.em_dest = em_dest;
    r.em_v    = em_v;
    r.mw_dest = mw_dest;
    r.mw_v    = mw_v;
    r.imm_v   = imm_v;
    r.imm     = imm;
    r.exp_res = exp;
    push_row(r);
  endtask

  task automatic md_row(input pip_types::muldiv_op_t md_op, input logic md_u,
                        input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
    row_t r;
    r         = blank_row(rows.size());
    r.md_op   = md_op;
    r.md_u    = md_u;
    r.a       = a;
    r.b       = b;
    r.chk_res = (md_op == pip_types::OP_MFHI || md_op == pip_types::OP_MFLO);
    r.exp_res = exp;
    push_row(r);
  endtask

  task automatic br_row(input pip_types::cond_t cond, input logic jmp, input logic fs,
                        input logic [31:0] a, input logic [31:0] b, input logic taken);
    row_t r;
    r           = blank_row(rows.size());
    r.cond      = cond;
    r.br        = !jmp;
    r.jmp       = jmp;
    r.fs        = fs;
    r.a         = a;
    r.b         = b;
    r.imm       = lcg_next() & 32'hffff_fffc;
    r.chk_res   = 1'b0;
    r.exp_npcv  = taken;
    r.exp_npc   = taken ? r.imm : r.pc;
    r.exp_stall = fs ? -1 : 0;
    push_row(r);
  endtask

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] ins_imm;
    logic [31:0] mask;
    logic [63:0] p;
    row_t        r;
    int          sa;
    int          sb;
    a = lcg_next();
    b = lcg_next();
    c = lcg_next();
    d = lcg_next();
    alu_row(pip_types::OP_ADD, pip_types::RES_ALU, 0, a, b, 0, 0, 0, 0, a + b);
    alu_row(pip_types::OP_SUB, pip_types::RES_ALU, 0, a, b, 0, 0, 0, 0, a - b);
    alu_row(pip_types::OP_OR, pip_types::RES_ALU, 0, a, b, 0, 0, 0, 0, a | b);
    alu_row(pip_types::OP_XOR, pip_types::RES_ALU, 0, a, b, 0, 0, 0, 0, a ^ b);
    alu_row(pip_types::OP_NOR, pip_types::RES_ALU, 0, a, b, 0, 0, 0, 0, ~(a | b));
    alu_row(pip_types::OP_AND, pip_types::RES_ALU, 0, a, b, 0, 0, 0, 0, a & b);
    alu_row(pip_types::OP_SLL, pip_types::RES_ALU, 0, a, b, 0, 0, 5'd7, 0, b << 7);
    alu_row(pip_types::OP_SRL, pip_types::RES_ALU, 0, a, b, 0, 0, 5'd2, 1, b >> a[4:0]);
    alu_row(pip_types::OP_SRA, pip_types::RES_ALU, 0, a, c | 32'h8000_0000, 0, 0, 5'd9, 0,
            32'($signed(c | 32'h8000_0000) >>> 9));
    alu_row(pip_types::OP_LUI, pip_types::RES_ALU, 0, a, b, c, 1, 0, 0, {c[15:0], 16'h0});
    alu_row(pip_types::OP_SEB, pip_types::RES_ALU, 0, a, d, 0, 0, 0, 0, {{24{d[7]}}, d[7:0]});
    alu_row(pip_types::OP_SEH, pip_types::RES_ALU, 0, a, d, 0, 0, 0, 0,
            {{16{d[15]}}, d[15:0]});
    // Field of 8 bits at bit 4
    ins_imm = (32'd7 << 11) | (32'd4 << 6);
    mask    = 32'h0000_0ff0;
    alu_row(pip_types::OP_EXT, pip_types::RES_ALU, 0, a, b, ins_imm, 0, 0, 0, (a >> 4) & 32'hff);
    alu_row(pip_types::OP_INS, pip_types::RES_ALU, 0, a, b, ins_imm, 1, 0, 0,
            ((a << 4) & mask) | (b & ~mask));
    alu_row(pip_types::OP_ADD, pip_types::RES_SET, 0, c | 32'h8000_0000, d & 32'h7fff_ffff,
            0, 0, 0, 0, 32'd1);
    alu_row(pip_types::OP_ADD, pip_types::RES_SET, 1, c | 32'h8000_0000, d & 32'h7fff_ffff,
            0, 0, 0, 0, 32'd0);
    alu_row(pip_types::OP_ADD, pip_types::RES_LINK, 0, a, b, 0, 0, 0, 0, 0);
    fwd_row(a, b, c, d, 5'd3, 1, 5'd9, 1, 0, 0, c + b);
    fwd_row(a, b, c, d, 5'd9, 1, 5'd4, 1, 0, 0, a + d);
    fwd_row(a, b, c, d, 5'd9, 1, 5'd3, 1, 0, 0, d + b);
    fwd_row(a, b, c, d, 5'd3, 1, 5'd3, 1, 0, 0, c + b);
    fwd_row(a, b, c, d, 5'd3, 0, 5'd9, 1, 0, 0, a + b);
    fwd_row(a, b, c, d, 5'd4, 1, 5'd9, 0, 1, 32'h0000_0123, a + 32'h0000_0123);
    p = 64'(longint'($signed(a)) * longint'($signed(b)));
    md_row(pip_types::OP_MUL, 0, a, b, 0);
    md_row(pip_types::OP_MFHI, 0, 0, 0, p[63:32]);
    md_row(pip_types::OP_MFLO, 0, 0, 0, p[31:0]);
    p = p + {32'b0, c} * {32'b0, d};
    md_row(pip_types::OP_MADD, 1, c, d, 0);
    md_row(pip_types::OP_MFHI, 0, 0, 0, p[63:32]);
    md_row(pip_types::OP_MFLO, 0, 0, 0, p[31:0]);
    md_row(pip_types::OP_DIV, 1, a, (b >> 20) | 32'd1, 0);
    md_row(pip_types::OP_MFLO, 0, 0, 0, a / ((b >> 20) | 32'd1));
    md_row(pip_types::OP_MFHI, 0, 0, 0, a % ((b >> 20) | 32'd1));
    // Signed divide with both operands forwarded while later stages move on mid-stall
    sa = -int'(c >> 4);
    sb = int'(d >> 24) + 3;
    r          = blank_row(rows.size());
    r.md_op    = pip_types::OP_DIV;
    r.chk_res  = 1'b0;
    r.a_reg    = 5'd7;
    r.b_reg    = 5'd8;
    r.a_v      = 1'b1;
    r.b_v      = 1'b1;
    r.em_dest  = 5'd7;
    r.mw_dest  = 5'd8;
    r.em_v     = 1'b1;
    r.mw_v     = 1'b1;
    r.em       = 32'(sa);
    r.mw       = 32'(sb);
    r.a        = a;
    r.b        = b;
    r.scramble = 1'b1;
    push_row(r);
    md_row(pip_types::OP_MFLO, 0, 0, 0, 32'(sa / sb));
    md_row(pip_types::OP_MFHI, 0, 0, 0, 32'(sa % sb));
    br_row(pip_types::COND_EQ, 0, 0, a, a, 1);
    br_row(pip_types::COND_NE, 0, 0, a, a, 0);
    br_row(pip_types::COND_GEZ, 0, 0, a & 32'h7fff_ffff, b, 1);
    br_row(pip_types::COND_GTZ, 0, 0, 32'd0, b, 0);
    br_row(pip_types::COND_LEZ, 0, 0, 32'd0, b, 1);
    br_row(pip_types::COND_LTZ, 0, 0, a | 32'h8000_0000, b, 1);
    br_row(pip_types::COND_NE, 1, 0, a, a, 1);
    br_row(pip_types::COND_NE, 1, 1, a, a, 0);
    alu_row(pip_types::OP_MOVZ, pip_types::RES_ALU, 0, a, 32'd0, 0, 0, 0, 0, a);
    alu_row(pip_types::OP_MOVZ, pip_types::RES_ALU, 0, a, b | 32'd1, 0, 0, 0, 0, a);
    alu_row(pip_types::OP_MOVN, pip_types::RES_ALU, 0, a, 32'd0, 0, 0, 0, 0, a);
    alu_row(pip_types::OP_MOVN, pip_types::RES_ALU, 0, a, b | 32'd1, 0, 0, 0, 0, a);
  endtask

  initial begin
    seed   = 32'hcc16_48ae;
    cur    = '0;
    chk_en = 1'b0;
    build_table();
    @(posedge reset_n);
    @(negedge clock);
    foreach (rows[i]) begin
      cur    = rows[i];
      chk_en = 1'b1;
      // Stall reflects the new row by the next falling edge
      @(negedge clock);
      if (cur.scramble) begin
        cur.em      = lcg_next();
        cur.mw      = lcg_next();
        cur.em_dest = 5'd20;
      end
      while (stall && !cur.fs)
        @(negedge clock);
      @(negedge clock);
    end
    chk_en = 1'b0;
    $display("Rows run: %0d, errors: %0d", rows.size(), errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial begin
    int limit;
    #1;
    limit = (rows.size() * (DIV_CYCLES + 4) + 8) * PERIOD;
    #(limit);
    $display("Timeout: the test did not finish within %0d ns", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* compile.f */
verilog/pip_types.sv
verilog/muldiv_if.sv
verilog/operand_forward.sv
verilog/alu.sv
verilog/muldiv_unit.sv
verilog/branch_unit.sv
verilog/ex_stage.sv
tb/tb_clock_gen.sv
tb/ex_checker.sv
tb/ex_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module ex_tb -f compile.f -o ex_tb_sim
./obj_dir/ex_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "Run ended without a result line"
  exit 1
fi
exit 0
